/* verilog/msx_io_settings.svh */
`ifndef MSX_IO_SETTINGS_SVH
`define MSX_IO_SETTINGS_SVH

// Set to 1 for the SVI port map, 0 for the MSX one
`define SVI_PORT_MAP 0

// VDP ports, write side
`define MSX_VDP_DATA_PORT    (`SVI_PORT_MAP ? 8'h80 : 8'h98)
`define MSX_VDP_CTRL_PORT    (`SVI_PORT_MAP ? 8'h81 : 8'h99)
// VDP ports, read side (same numbers on MSX)
`define MSX_VDP_DATA_RD_PORT (`SVI_PORT_MAP ? 8'h84 : 8'h98)
`define MSX_VDP_CTRL_RD_PORT (`SVI_PORT_MAP ? 8'h85 : 8'h99)

// PPI
`define MSX_PPI_A_PORT       (`SVI_PORT_MAP ? 8'h98 : 8'ha8)
`define MSX_PPI_B_PORT       (`SVI_PORT_MAP ? 8'h99 : 8'ha9)
`define MSX_PPI_C_PORT       (`SVI_PORT_MAP ? 8'h96 : 8'haa)
`define MSX_PPI_CMD_PORT     (`SVI_PORT_MAP ? 8'h97 : 8'hab)

// PSG
`define MSX_PSG_REG_PORT     (`SVI_PORT_MAP ? 8'h88 : 8'ha0)
`define MSX_PSG_WR_PORT      (`SVI_PORT_MAP ? 8'h8c : 8'ha1)
`define MSX_PSG_RD_PORT      (`SVI_PORT_MAP ? 8'h90 : 8'ha2)

`define MSX_CLOCK_DIVIDE     7   // cpuClock cycles per CPU cycle
`define MSX_VDP_REG_COUNT    8
`define MSX_JOYSTICK_PSG_REG 14

`endif

/* verilog/msx_io_pkg.sv */
`default_nettype none

package msx_io_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] cpu_addr_t;
  typedef logic [13:0] vram_addr_t;  // 16 KB of VRAM

  // Screen modes as seen by the renderer
  typedef enum logic [1:0] {
    MODE_GRAPHIC1   = 2'd0,
    MODE_TEXT       = 2'd1,
    MODE_GRAPHIC2   = 2'd2,
    MODE_MULTICOLOR = 2'd3
  } vdp_mode_t;

  // Primary slot number, one per 16 KB page
  typedef logic [1:0] slot_t;

endpackage

`default_nettype wire

/* verilog/cpu_clock_enable.sv */
`default_nettype none
`timescale 1ns/1ps
`include "msx_io_settings.svh"

module cpu_clock_enable (
  input  wire  i_cpu_clock,
  input  wire  i_n_hard_reset,
  output logic o_clock_enable,
  output logic o_clock_edge
);

  localparam int unsigned DIVIDE = `MSX_CLOCK_DIVIDE;
  localparam int unsigned CW     = $clog2(DIVIDE);

  logic [CW-1:0] count;
  logic          enable_d;  // Enable one cycle late

  always_ff @(posedge i_cpu_clock) begin
    if (!i_n_hard_reset) begin
      count    <= '0;
      enable_d <= 1'b0;
    end else begin
      enable_d <= o_clock_enable;
      if (count == CW'(DIVIDE - 1)) count <= '0;
      else count <= count + 1'b1;
    end
  end

  // High for the last three counts of each period
  assign o_clock_enable = (count >= CW'(DIVIDE - 3));
  assign o_clock_edge   = o_clock_enable && !enable_d;

  // One edge per period, never two in a row
  a_edge_period : assert property (@(posedge i_cpu_clock) disable iff (!i_n_hard_reset)
    o_clock_edge |=> !o_clock_edge [*DIVIDE-1] ##1 o_clock_edge);

endmodule

`default_nettype wire

/* verilog/io_port_decoder.sv */
`default_nettype none
`timescale 1ns/1ps
`include "msx_io_settings.svh"

module io_port_decoder (
  input  msx_io_pkg::cpu_addr_t i_cpu_address,
  input  wire                   i_n_iorq,
  input  wire                   i_n_rd,
  input  wire                   i_n_wr,
  output logic                  o_vdp_data_wr,
  output logic                  o_vdp_ctrl_wr,
  output logic                  o_ppi_a_wr,
  output logic                  o_ppi_c_wr,
  output logic                  o_ppi_cmd_wr,
  output logic                  o_psg_reg_wr,
  output logic                  o_vdp_data_rd,
  output logic                  o_vdp_status_rd,
  output logic                  o_ppi_a_rd,
  output logic                  o_ppi_b_rd,
  output logic                  o_ppi_c_rd,
  output logic                  o_psg_val_rd
);

  logic [7:0] port;
  logic       io_wr;
  logic       io_rd;

  assign port  = i_cpu_address[7:0];  // Only the low byte selects a port
  assign io_wr = !i_n_iorq && !i_n_wr;
  assign io_rd = !i_n_iorq && !i_n_rd;

  // Write strobes
  assign o_vdp_data_wr   = io_wr && (port == `MSX_VDP_DATA_PORT);
  assign o_vdp_ctrl_wr   = io_wr && (port == `MSX_VDP_CTRL_PORT);
  assign o_ppi_a_wr      = io_wr && (port == `MSX_PPI_A_PORT);
  assign o_ppi_c_wr      = io_wr && (port == `MSX_PPI_C_PORT);
  assign o_ppi_cmd_wr    = io_wr && (port == `MSX_PPI_CMD_PORT);
  assign o_psg_reg_wr    = io_wr && (port == `MSX_PSG_REG_PORT);

  // Read strobes
  assign o_vdp_data_rd   = io_rd && (port == `MSX_VDP_DATA_RD_PORT);
  assign o_vdp_status_rd = io_rd && (port == `MSX_VDP_CTRL_RD_PORT);
  assign o_ppi_a_rd      = io_rd && (port == `MSX_PPI_A_PORT);
  assign o_ppi_b_rd      = io_rd && (port == `MSX_PPI_B_PORT);
  assign o_ppi_c_rd      = io_rd && (port == `MSX_PPI_C_PORT);
  assign o_psg_val_rd    = io_rd && (port == `MSX_PSG_RD_PORT);

  // The bus master must never drive RD and WR together
  always_comb begin
    a_rd_wr_excl : assert #0 (!(io_rd === 1'b1 && io_wr === 1'b1));
  end

endmodule

`default_nettype wire

/* verilog/vdp_port.sv */
`default_nettype none
`timescale 1ns/1ps
`include "msx_io_settings.svh"

module vdp_port (
  input  wire                    i_cpu_clock,
  input  wire                    i_n_hard_reset,
  input  wire                    i_clock_edge,
  input  wire                    i_data_wr,
  input  wire                    i_ctrl_wr,
  input  wire                    i_data_rd,
  input  msx_io_pkg::byte_t      i_cpu_data,
  output msx_io_pkg::vram_addr_t o_vram_addr,
  output logic                   o_vram_wr,
  output logic                   o_vram_rd,
  output msx_io_pkg::vdp_mode_t  o_mode,
  output msx_io_pkg::vram_addr_t o_name_table_addr,
  output msx_io_pkg::vram_addr_t o_color_table_addr,
  output msx_io_pkg::vram_addr_t o_pattern_table_addr,
  output msx_io_pkg::vram_addr_t o_sprite_attr_addr,
  output msx_io_pkg::vram_addr_t o_sprite_pattern_addr,
  output logic                   o_video_on,
  output logic                   o_vblank_int_en,
  output logic                   o_sprite_large,
  output logic                   o_sprite_magnify,
  output logic [3:0]             o_text_color,
  output logic [3:0]             o_back_color
);

  import msx_io_pkg::*;

  localparam int unsigned REG_COUNT = `MSX_VDP_REG_COUNT;
  localparam int unsigned REG_AW    = $clog2(REG_COUNT);

  byte_t      regs [REG_COUNT];
  byte_t      first_byte;   // First half of a control pair
  logic       second_byte;
  logic       data_rd_d;    // Read strobe seen at the previous edge
  logic       graphic2;

  // ======================================================================
  // Control port and VRAM pointer
  // ======================================================================
  always_ff @(posedge i_cpu_clock) begin
    if (!i_n_hard_reset) begin
      o_vram_addr <= '0;
      second_byte <= 1'b0;
      data_rd_d   <= 1'b0;
      for (int i = 0; i < REG_COUNT; i++) regs[i] <= '0;
    end else if (i_clock_edge) begin
      data_rd_d <= i_data_rd;
      // Advance after a write, or once a read has finished
      if (i_data_wr || (data_rd_d && !i_data_rd)) o_vram_addr <= o_vram_addr + 1'b1;
      if (i_ctrl_wr) begin
        second_byte <= !second_byte;
        if (second_byte) begin
          if (!i_cpu_data[7]) begin
            o_vram_addr <= {i_cpu_data[5:0], first_byte};
          end else if (i_cpu_data[5:0] < 6'(REG_COUNT)) begin
            regs[i_cpu_data[REG_AW-1:0]] <= first_byte;
          end
        end
      end
    end
  end

  always_ff @(posedge i_cpu_clock) begin
    if (i_clock_edge && i_ctrl_wr && !second_byte) first_byte <= i_cpu_data;
  end

  assign o_vram_wr = i_data_wr && i_clock_edge;
  assign o_vram_rd = i_data_rd && i_clock_edge;

  // ======================================================================
  // Register decode
  // ======================================================================
  assign o_mode = regs[1][3] ? MODE_MULTICOLOR :
                  regs[0][1] ? MODE_GRAPHIC2 :
                  regs[1][4] ? MODE_TEXT : MODE_GRAPHIC1;
  assign graphic2 = (o_mode == MODE_GRAPHIC2);

  assign o_name_table_addr     = {regs[2][3:0], 10'b0};
  assign o_color_table_addr    = graphic2 ? {regs[3][7], 13'b0} : {regs[3], 6'b0};
  assign o_pattern_table_addr  = graphic2 ? {regs[4][2], 13'b0} : {regs[4][2:0], 11'b0};
  assign o_sprite_attr_addr    = {regs[5][6:0], 7'b0};
  assign o_sprite_pattern_addr = {regs[6][2:0], 11'b0};

  assign o_video_on       = regs[1][6];
  assign o_vblank_int_en  = regs[1][5];
  assign o_sprite_large   = regs[1][1];  // 16x16 sprites
  assign o_sprite_magnify = regs[1][0];
  assign o_text_color     = regs[7][7:4];
  assign o_back_color     = regs[7][3:0];

  // Decoder keeps data read and write apart
  a_vram_rw_excl : assert property (@(posedge i_cpu_clock) disable iff (!i_n_hard_reset)
    !(o_vram_wr && o_vram_rd));

endmodule

`default_nettype wire

/* verilog/vdp_status.sv */
`default_nettype none
`timescale 1ns/1ps

module vdp_status (
  input  wire               i_cpu_clock,
  input  wire               i_n_hard_reset,
  input  wire               i_clock_edge,
  input  wire               i_status_rd,
  input  wire               i_interrupt_flag,
  input  wire               i_sprite_collision,
  input  wire               i_too_many_sprites,
  input  wire  [4:0]        i_sprite5,
  output msx_io_pkg::byte_t o_status
);

  logic int_flag;
  logic coll_flag;
  logic status_rd_d;

  always_ff @(posedge i_cpu_clock) begin
    if (!i_n_hard_reset) begin
      int_flag    <= 1'b0;
      coll_flag   <= 1'b0;
      status_rd_d <= 1'b0;
    end else begin
      if (i_clock_edge) begin
        status_rd_d <= i_status_rd;
        // Clear once the status read is over
        if (status_rd_d && !i_status_rd) begin
          int_flag  <= 1'b0;
          coll_flag <= 1'b0;
        end
      end
      // Sets come last so they beat a clear in the same cycle
      if (i_interrupt_flag) int_flag <= 1'b1;
      if (i_sprite_collision) coll_flag <= 1'b1;
    end
  end

  assign o_status = {int_flag, i_too_many_sprites, coll_flag,
                     (i_too_many_sprites ? i_sprite5 : 5'b11111)};

endmodule

`default_nettype wire

/* verilog/ppi_ports.sv */
`default_nettype none
`timescale 1ns/1ps

module ppi_ports (
  input  wire               i_cpu_clock,
  input  wire               i_n_hard_reset,
  input  wire               i_clock_edge,
  input  wire               i_port_a_wr,
  input  wire               i_port_c_wr,
  input  wire               i_cmd_wr,
  input  msx_io_pkg::byte_t i_cpu_data,
  output msx_io_pkg::byte_t o_port_a,
  output msx_io_pkg::byte_t o_port_c
);

  import msx_io_pkg::*;

  slot_t page_slot [4];  // Slot for each 16 KB page

  always_ff @(posedge i_cpu_clock) begin
    if (!i_n_hard_reset) begin
      for (int i = 0; i < 4; i++) page_slot[i] <= '0;
      o_port_c <= '0;
    end else if (i_clock_edge) begin
      if (i_port_a_wr) begin
        for (int i = 0; i < 4; i++) page_slot[i] <= i_cpu_data[2*i +: 2];
      end
      if (i_port_c_wr) o_port_c <= i_cpu_data;
      // Bit set/reset: bits 3..1 pick the bit, bit 0 is the value
      if (i_cmd_wr && !i_cpu_data[7]) o_port_c[i_cpu_data[3:1]] <= i_cpu_data[0];
    end
  end

  assign o_port_a = {page_slot[3], page_slot[2], page_slot[1], page_slot[0]};

endmodule

`default_nettype wire

/* verilog/slot_read_select.sv */
`default_nettype none
`timescale 1ns/1ps
`include "msx_io_settings.svh"

module slot_read_select (
  input  wire                   i_cpu_clock,
  input  wire                   i_n_hard_reset,
  input  wire                   i_clock_edge,
  input  msx_io_pkg::cpu_addr_t i_cpu_address,
  input  wire                   i_n_mreq,
  input  wire                   i_n_rd,
  input  wire                   i_n_wr,
  input  msx_io_pkg::byte_t     i_cpu_data,
  input  wire                   i_psg_reg_wr,
  input  wire                   i_psg_val_rd,
  input  wire                   i_ppi_a_rd,
  input  wire                   i_ppi_b_rd,
  input  wire                   i_ppi_c_rd,
  input  wire                   i_vdp_data_rd,
  input  wire                   i_vdp_status_rd,
  input  msx_io_pkg::byte_t     i_port_a,
  input  msx_io_pkg::byte_t     i_port_c,
  input  msx_io_pkg::byte_t     i_keyboard_row,
  input  msx_io_pkg::byte_t     i_vram_data,
  input  msx_io_pkg::byte_t     i_status,
  input  msx_io_pkg::byte_t     i_ram_data,
  input  msx_io_pkg::byte_t     i_rom_data,
  input  wire  [6:1]            i_buttons,       // Active low
  input  wire                   i_rom_page1_en,
  output msx_io_pkg::byte_t     o_cpu_data_in,
  output logic                  o_ram_we,
  output logic [3:0]            o_psg_reg
);

  import msx_io_pkg::*;

  localparam slot_t RAM_SLOT  = 2'd0;
  localparam slot_t CART_SLOT = 2'd1;

  logic [1:0] page;
  slot_t      cur_slot;
  logic       mem_rd;
  logic       mem_wr;
  byte_t      joystick;

  always_ff @(posedge i_cpu_clock) begin
    if (!i_n_hard_reset) o_psg_reg <= '0;
    else if (i_clock_edge && i_psg_reg_wr) o_psg_reg <= i_cpu_data[3:0];
  end

  assign page     = i_cpu_address[15:14];
  assign cur_slot = i_port_a[{page, 1'b0} +: 2];  // Slot field of the addressed page
  assign mem_rd   = !i_n_mreq && !i_n_rd;
  assign mem_wr   = !i_n_mreq && !i_n_wr;
  assign joystick = {2'b00, ~i_buttons[2:1], ~i_buttons[6:3]};

  // ======================================================================
  // CPU read multiplexer, highest priority first
  // ======================================================================
  always_comb begin
    if (i_ppi_a_rd) o_cpu_data_in = i_port_a;
    else if (i_ppi_b_rd) o_cpu_data_in = i_keyboard_row;
    else if (i_ppi_c_rd) o_cpu_data_in = i_port_c;
    else if (i_vdp_data_rd) o_cpu_data_in = i_vram_data;
    else if (i_vdp_status_rd) o_cpu_data_in = i_status;
    else if (i_psg_val_rd && o_psg_reg == 4'(`MSX_JOYSTICK_PSG_REG)) o_cpu_data_in = joystick;
    else if (mem_rd && page == 2'd1 && i_port_a[3:2] == CART_SLOT && i_rom_page1_en)
      o_cpu_data_in = i_rom_data;  // Cartridge, page 1
    else if (mem_rd && page == 2'd2 && i_port_a[5:4] == CART_SLOT)
      o_cpu_data_in = i_rom_data;
    else if (cur_slot == RAM_SLOT) o_cpu_data_in = i_ram_data;
    else o_cpu_data_in = '0;
  end

  // RAM lives in the upper 32 KB of slot 0
  assign o_ram_we = i_cpu_address[15] && cur_slot == RAM_SLOT && mem_wr;

endmodule

`default_nettype wire

/* verilog/msx_io_glue.sv */
`default_nettype none
`timescale 1ns/1ps

module msx_io_glue (
  input  wire                    cpuClock,
  input  wire                    n_hard_reset,
  // Z80 bus
  input  msx_io_pkg::cpu_addr_t  i_cpu_address,
  input  msx_io_pkg::byte_t      i_cpu_data,
  input  wire                    i_n_iorq,
  input  wire                    i_n_mreq,
  input  wire                    i_n_rd,
  input  wire                    i_n_wr,
  // Surrounding chips
  input  msx_io_pkg::byte_t      i_keyboard_row,
  input  msx_io_pkg::byte_t      i_vram_data,
  input  msx_io_pkg::byte_t      i_ram_data,
  input  msx_io_pkg::byte_t      i_rom_data,
  input  wire  [6:1]             i_buttons,
  input  wire                    i_rom_page1_en,
  input  wire                    i_interrupt_flag,
  input  wire                    i_sprite_collision,
  input  wire                    i_too_many_sprites,
  input  wire  [4:0]             i_sprite5,
  output logic                   o_cpu_clock_enable,
  output msx_io_pkg::byte_t      o_cpu_data_in,
  output logic                   o_ram_we,
  output logic [3:0]             o_psg_reg,
  output msx_io_pkg::byte_t      o_ppi_port_a,
  output msx_io_pkg::byte_t      o_ppi_port_c,
  // VDP side
  output msx_io_pkg::vram_addr_t o_vram_addr,
  output logic                   o_vram_wr,
  output logic                   o_vram_rd,
  output msx_io_pkg::vdp_mode_t  o_mode,
  output msx_io_pkg::vram_addr_t o_name_table_addr,
  output msx_io_pkg::vram_addr_t o_color_table_addr,
  output msx_io_pkg::vram_addr_t o_pattern_table_addr,
  output msx_io_pkg::vram_addr_t o_sprite_attr_addr,
  output msx_io_pkg::vram_addr_t o_sprite_pattern_addr,
  output logic                   o_video_on,
  output logic                   o_vblank_int_en,
  output logic                   o_sprite_large,
  output logic                   o_sprite_magnify,
  output logic [3:0]             o_text_color,
  output logic [3:0]             o_back_color
);

  import msx_io_pkg::*;

  logic  clock_edge;
  logic  vdp_data_wr, vdp_ctrl_wr, ppi_a_wr, ppi_c_wr, ppi_cmd_wr, psg_reg_wr;
  logic  vdp_data_rd, vdp_status_rd, ppi_a_rd, ppi_b_rd, ppi_c_rd, psg_val_rd;
  byte_t status;

  cpu_clock_enable cpu_clock_enable_i (
    .i_cpu_clock(cpuClock), .i_n_hard_reset(n_hard_reset),
    .o_clock_enable(o_cpu_clock_enable), .o_clock_edge(clock_edge)
  );

  io_port_decoder io_port_decoder_i (
    .i_cpu_address(i_cpu_address), .i_n_iorq(i_n_iorq), .i_n_rd(i_n_rd), .i_n_wr(i_n_wr),
    .o_vdp_data_wr(vdp_data_wr), .o_vdp_ctrl_wr(vdp_ctrl_wr), .o_ppi_a_wr(ppi_a_wr),
    .o_ppi_c_wr(ppi_c_wr), .o_ppi_cmd_wr(ppi_cmd_wr), .o_psg_reg_wr(psg_reg_wr),
    .o_vdp_data_rd(vdp_data_rd), .o_vdp_status_rd(vdp_status_rd), .o_ppi_a_rd(ppi_a_rd),
    .o_ppi_b_rd(ppi_b_rd), .o_ppi_c_rd(ppi_c_rd), .o_psg_val_rd(psg_val_rd)
  );

  vdp_port vdp_port_i (
    .i_cpu_clock(cpuClock), .i_n_hard_reset(n_hard_reset), .i_clock_edge(clock_edge),
    .i_data_wr(vdp_data_wr), .i_ctrl_wr(vdp_ctrl_wr), .i_data_rd(vdp_data_rd),
    .i_cpu_data(i_cpu_data),
    .o_vram_addr(o_vram_addr), .o_vram_wr(o_vram_wr), .o_vram_rd(o_vram_rd), .o_mode(o_mode),
    .o_name_table_addr(o_name_table_addr), .o_color_table_addr(o_color_table_addr),
    .o_pattern_table_addr(o_pattern_table_addr), .o_sprite_attr_addr(o_sprite_attr_addr),
    .o_sprite_pattern_addr(o_sprite_pattern_addr), .o_video_on(o_video_on),
    .o_vblank_int_en(o_vblank_int_en), .o_sprite_large(o_sprite_large),
    .o_sprite_magnify(o_sprite_magnify), .o_text_color(o_text_color),
    .o_back_color(o_back_color)
  );

  vdp_status vdp_status_i (
    .i_cpu_clock(cpuClock), .i_n_hard_reset(n_hard_reset), .i_clock_edge(clock_edge),
    .i_status_rd(vdp_status_rd), .i_interrupt_flag(i_interrupt_flag),
    .i_sprite_collision(i_sprite_collision), .i_too_many_sprites(i_too_many_sprites),
    .i_sprite5(i_sprite5), .o_status(status)
  );

  ppi_ports ppi_ports_i (
    .i_cpu_clock(cpuClock), .i_n_hard_reset(n_hard_reset), .i_clock_edge(clock_edge),
    .i_port_a_wr(ppi_a_wr), .i_port_c_wr(ppi_c_wr), .i_cmd_wr(ppi_cmd_wr),
    .i_cpu_data(i_cpu_data), .o_port_a(o_ppi_port_a), .o_port_c(o_ppi_port_c)
  );

  slot_read_select slot_read_select_i (
    .i_cpu_clock(cpuClock), .i_n_hard_reset(n_hard_reset), .i_clock_edge(clock_edge),
    .i_cpu_address(i_cpu_address), .i_n_mreq(i_n_mreq), .i_n_rd(i_n_rd), .i_n_wr(i_n_wr),
    .i_cpu_data(i_cpu_data), .i_psg_reg_wr(psg_reg_wr), .i_psg_val_rd(psg_val_rd),
    .i_ppi_a_rd(ppi_a_rd), .i_ppi_b_rd(ppi_b_rd), .i_ppi_c_rd(ppi_c_rd),
    .i_vdp_data_rd(vdp_data_rd), .i_vdp_status_rd(vdp_status_rd),
    .i_port_a(o_ppi_port_a), .i_port_c(o_ppi_port_c), .i_keyboard_row(i_keyboard_row),
    .i_vram_data(i_vram_data), .i_status(status), .i_ram_data(i_ram_data),
    .i_rom_data(i_rom_data), .i_buttons(i_buttons), .i_rom_page1_en(i_rom_page1_en),
    .o_cpu_data_in(o_cpu_data_in), .o_ram_we(o_ram_we), .o_psg_reg(o_psg_reg)
  );

endmodule

`default_nettype wire

/* testbench/tb_msx_io_glue.sv */
`default_nettype none
`timescale 1ns/1ps
`include "msx_io_settings.svh"

module tb_msx_io_glue;

  import msx_io_pkg::*;

  localparam int unsigned CYCLE_LIMIT = 20000;  // About 20x the ~1000 cycles the tests take
  localparam time         DRIVE_DELAY = 1ns;

  // DUT inputs
  logic       cpuClock;
  logic       n_hard_reset;
  cpu_addr_t  i_cpu_address;
  byte_t      i_cpu_data;
  logic       i_n_iorq, i_n_mreq, i_n_rd, i_n_wr;
  byte_t      i_keyboard_row, i_vram_data, i_ram_data, i_rom_data;
  logic [6:1] i_buttons;
  logic       i_rom_page1_en, i_interrupt_flag, i_sprite_collision, i_too_many_sprites;
  logic [4:0] i_sprite5;
  // DUT outputs
  logic       o_cpu_clock_enable, o_ram_we, o_vram_wr, o_vram_rd;
  byte_t      o_cpu_data_in, o_ppi_port_a, o_ppi_port_c;
  logic [3:0] o_psg_reg, o_text_color, o_back_color;
  vram_addr_t o_vram_addr, o_name_table_addr, o_color_table_addr, o_pattern_table_addr;
  vram_addr_t o_sprite_attr_addr, o_sprite_pattern_addr;
  vdp_mode_t  o_mode;
  logic       o_video_on, o_vblank_int_en, o_sprite_large, o_sprite_magnify;

  // Expected state, kept by the stimulus
  int unsigned cycle = 0;
  int unsigned error_count = 0;
  int unsigned vram_wr_count = 0;
  logic        rd_check = 1'b0;
  byte_t       rd_expect = '0;
  logic        we_expect = 1'b0;
  logic        vram_wr_allowed = 1'b0;
  logic        vram_rd_allowed = 1'b0;
  vram_addr_t  vram_expect = '0;
  logic        regs_valid = 1'b0;
  vdp_mode_t   mode_expect = MODE_GRAPHIC1;
  vram_addr_t  name_expect = '0;
  vram_addr_t  color_expect = '0;
  vram_addr_t  pattern_expect = '0;
  vram_addr_t  attr_expect = '0;
  vram_addr_t  sprite_pat_expect = '0;
  byte_t       r1_expect = '0;
  byte_t       r7_expect = '0;

  msx_io_glue msx_io_glue_i (.*);

  initial begin
    cpuClock = 1'b0;
    forever #5 cpuClock = ~cpuClock;
  end

  always @(posedge cpuClock) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $fatal(1, "Timeout");
    end
  end

  always @(negedge cpuClock) begin
    if (o_vram_wr) vram_wr_count <= vram_wr_count + 1;  // Counted where the pulse is stable
  end

  task automatic report_error(input string msg);
    error_count++;
    $display("[FAIL] %0t: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  // ======================================================================
  // Checking
  // ======================================================================
  a_enable_in_reset : assert property (@(posedge cpuClock)
    (!n_hard_reset && cycle > 1) |-> !o_cpu_clock_enable)
    else report_error("CPU clock enable high during reset");

  // 3 high, 4 low
  a_enable_period : assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    $rose(o_cpu_clock_enable) |->
      o_cpu_clock_enable [*3] ##1 !o_cpu_clock_enable [*4] ##1 o_cpu_clock_enable)
    else report_error("CPU clock enable does not repeat every 7 cycles");

  a_read_data : assert property (@(posedge cpuClock) rd_check |-> o_cpu_data_in == rd_expect)
    else report_error($sformatf("read data %02h, expected %02h",
                                $sampled(o_cpu_data_in), $sampled(rd_expect)));

  a_ram_we : assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    o_ram_we == we_expect)
    else report_error($sformatf("RAM write enable %b, expected %b",
                                $sampled(o_ram_we), $sampled(we_expect)));

  a_vram_wr : assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    o_vram_wr |-> vram_wr_allowed && o_vram_addr == vram_expect)
    else report_error($sformatf("VRAM write at %04h, expected one at %04h",
                                $sampled(o_vram_addr), $sampled(vram_expect)));

  a_vram_wr_single : assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    o_vram_wr |=> !o_vram_wr)
    else report_error("VRAM write pulse wider than one cycle");

  a_vram_rd : assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    o_vram_rd |-> vram_rd_allowed)
    else report_error("VRAM read pulse outside a data port read");

  a_vdp_regs : assert property (@(posedge cpuClock) regs_valid |->
    o_mode == mode_expect && o_name_table_addr == name_expect &&
    o_color_table_addr == color_expect && o_pattern_table_addr == pattern_expect &&
    o_sprite_attr_addr == attr_expect && o_sprite_pattern_addr == sprite_pat_expect &&
    o_video_on == r1_expect[6] && o_vblank_int_en == r1_expect[5] &&
    o_sprite_large == r1_expect[1] && o_sprite_magnify == r1_expect[0] &&
    o_text_color == r7_expect[7:4] && o_back_color == r7_expect[3:0])
    else report_error("VDP register decode does not match the written registers");

  // ======================================================================
  // Bus tasks and models
  // ======================================================================
  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(posedge cpuClock);
    #DRIVE_DELAY;
  endtask

  // Hold the access for 7 cycles, then idle for one
  task automatic finish_access();
    repeat (7) @(posedge cpuClock);
    #DRIVE_DELAY;
    i_n_iorq = 1'b1;
    i_n_mreq = 1'b1;
    i_n_rd = 1'b1;
    i_n_wr = 1'b1;
    rd_check = 1'b0;
    we_expect = 1'b0;
    vram_wr_allowed = 1'b0;
    vram_rd_allowed = 1'b0;
    idle_cycles(1);
  endtask

  task automatic io_write(input byte_t port, input byte_t data);
    i_cpu_address = {8'($urandom), port};  // High byte is don't care
    i_cpu_data = data;
    i_n_iorq = 1'b0;
    i_n_wr = 1'b0;
    vram_wr_allowed = (port == `MSX_VDP_DATA_PORT);
    finish_access();
  endtask

  task automatic io_read(input byte_t port, input byte_t expect_data);
    i_cpu_address = {8'($urandom), port};
    i_n_iorq = 1'b0;
    i_n_rd = 1'b0;
    rd_expect = expect_data;
    rd_check = 1'b1;
    vram_rd_allowed = (port == `MSX_VDP_DATA_RD_PORT);
    finish_access();
  endtask

  task automatic mem_read(input cpu_addr_t addr, input byte_t expect_data);
    i_cpu_address = addr;
    i_n_mreq = 1'b0;
    i_n_rd = 1'b0;
    rd_expect = expect_data;
    rd_check = 1'b1;
    finish_access();
  endtask

  task automatic mem_write(input cpu_addr_t addr, input byte_t data, input logic we);
    i_cpu_address = addr;
    i_cpu_data = data;
    i_n_mreq = 1'b0;
    i_n_wr = 1'b0;
    we_expect = we;
    finish_access();
  endtask

  task automatic vdp_write_reg(input int unsigned num, input byte_t value);
    io_write(`MSX_VDP_CTRL_PORT, value);
    io_write(`MSX_VDP_CTRL_PORT, 8'h80 | 8'(num));
  endtask

  task automatic vdp_set_pointer(input vram_addr_t addr);
    io_write(`MSX_VDP_CTRL_PORT, addr[7:0]);
    io_write(`MSX_VDP_CTRL_PORT, {2'b01, addr[13:8]});  // Bit 6 is the write-mode hint
    vram_expect = addr;
  endtask

  // Flags set, read back, then found clear by a second read
  task automatic check_sticky_status(input logic irq, input logic coll);
    logic [4:0] low_bits;
    i_too_many_sprites = 1'($urandom);
    i_sprite5 = 5'($urandom);
    low_bits = i_too_many_sprites ? i_sprite5 : 5'h1f;
    i_interrupt_flag = irq;
    i_sprite_collision = coll;
    idle_cycles(1);
    i_interrupt_flag = 1'b0;
    i_sprite_collision = 1'b0;
    io_read(`MSX_VDP_CTRL_RD_PORT, {irq, i_too_many_sprites, coll, low_bits});
    idle_cycles(7);  // Guarantees a CPU edge for the clear
    io_read(`MSX_VDP_CTRL_RD_PORT, {1'b0, i_too_many_sprites, 1'b0, low_bits});
    idle_cycles(7);
  endtask

  function automatic vdp_mode_t expected_mode(input byte_t r0, input byte_t r1);
    if (r1[3]) return MODE_MULTICOLOR;
    if (r0[1]) return MODE_GRAPHIC2;
    if (r1[4]) return MODE_TEXT;
    return MODE_GRAPHIC1;
  endfunction

  function automatic byte_t expected_mem_data(input cpu_addr_t addr, input byte_t slots,
                                              input logic page1_rom, input byte_t ram,
                                              input byte_t rom);
    logic [1:0] page;
    logic [1:0] slot;
    page = addr[15:14];
    slot = slots[2*page +: 2];
    if (slot == 2'd1 && (page == 2'd2 || (page == 2'd1 && page1_rom))) return rom;
    if (slot == 2'd0) return ram;
    return 8'h00;
  endfunction

  // ======================================================================
  // Stimulus
  // ======================================================================
  initial begin
    byte_t       r1, r2, r3, r4, r5, r6, r7;
    byte_t       a_val, c_val, cmd;
    cpu_addr_t   addr;
    logic [1:0]  slot;
    int unsigned writes;
    void'($urandom(32'h3d36_83cc));
    n_hard_reset = 1'b0;
    i_cpu_address = '0;
    i_cpu_data = '0;
    i_n_iorq = 1'b1;
    i_n_mreq = 1'b1;
    i_n_rd = 1'b1;
    i_n_wr = 1'b1;
    i_keyboard_row = '0;
    i_vram_data = '0;
    i_ram_data = '0;
    i_rom_data = '0;
    i_buttons = '1;
    i_rom_page1_en = 1'b0;
    i_interrupt_flag = 1'b0;
    i_sprite_collision = 1'b0;
    i_too_many_sprites = 1'b0;
    i_sprite5 = '0;
    idle_cycles(16);
    n_hard_reset = 1'b1;

    assert (o_ppi_port_a == 0 && o_ppi_port_c == 0 && o_vram_addr == 0 &&
            o_mode == MODE_GRAPHIC1 && o_name_table_addr == 0)
      else report_error("register state after reset is not zero");
    io_read(`MSX_VDP_CTRL_RD_PORT, 8'h1f);  // No flags after reset

    // Video registers
    r1 = 8'($urandom);
    r2 = 8'($urandom);
    r3 = 8'($urandom);
    r4 = 8'($urandom);
    r5 = 8'($urandom);
    r6 = 8'($urandom);
    r7 = 8'($urandom);
    vdp_write_reg(1, r1);
    vdp_write_reg(2, r2);
    vdp_write_reg(3, r3);
    vdp_write_reg(4, r4);
    vdp_write_reg(5, r5);
    vdp_write_reg(6, r6);
    vdp_write_reg(7, r7);
    mode_expect = expected_mode(8'h00, r1);
    name_expect = vram_addr_t'(32'(r2) * 1024);
    // Register 0 stays zero, so the graphic 2 table rules never apply
    color_expect = vram_addr_t'(32'(r3) * 64);
    pattern_expect = vram_addr_t'(32'(r4) * 2048);
    attr_expect = vram_addr_t'(32'(r5) * 128);
    sprite_pat_expect = vram_addr_t'(32'(r6) * 2048);
    r1_expect = r1;
    r7_expect = r7;
    regs_valid = 1'b1;

    // VRAM pointer, writes and one read
    vdp_set_pointer(14'($urandom));
    writes = vram_wr_count;
    for (int i = 0; i < 6; i++) begin
      io_write(`MSX_VDP_DATA_PORT, 8'($urandom));
      vram_expect = vram_expect + 14'd1;
    end
    assert (vram_wr_count == writes + 6)
      else report_error("wrong number of VRAM write pulses");
    i_vram_data = 8'($urandom);
    io_read(`MSX_VDP_DATA_RD_PORT, i_vram_data);
    idle_cycles(7);
    vram_expect = vram_expect + 14'd1;
    assert (o_vram_addr == vram_expect)
      else report_error("VRAM pointer did not advance after a data read");

    check_sticky_status(1'b1, 1'b0);
    check_sticky_status(1'b0, 1'b1);
    check_sticky_status(1'b1, 1'b1);

    // PPI ports and joystick
    a_val = 8'($urandom);
    c_val = 8'($urandom);
    io_write(`MSX_PPI_A_PORT, a_val);
    io_write(`MSX_PPI_C_PORT, c_val);
    for (int i = 0; i < 4; i++) begin
      cmd = {1'b0, 7'($urandom)};
      io_write(`MSX_PPI_CMD_PORT, cmd);
      c_val[cmd[3:1]] = cmd[0];
    end
    assert (o_ppi_port_a == a_val && o_ppi_port_c == c_val)
      else report_error("PPI port outputs do not match the written values");
    io_read(`MSX_PPI_A_PORT, a_val);
    io_read(`MSX_PPI_C_PORT, c_val);
    i_keyboard_row = 8'($urandom);
    io_read(`MSX_PPI_B_PORT, i_keyboard_row);
    io_write(`MSX_PSG_REG_PORT, 8'(`MSX_JOYSTICK_PSG_REG));
    assert (o_psg_reg == 4'(`MSX_JOYSTICK_PSG_REG))
      else report_error("PSG register select does not hold the written number");
    i_buttons = 6'($urandom);
    io_read(`MSX_PSG_RD_PORT, {2'b00, ~i_buttons[2:1], ~i_buttons[6:3]});

    // Slot selection, read mux and RAM write enable
    for (int i = 0; i < 24; i++) begin
      a_val = 8'($urandom);
      io_write(`MSX_PPI_A_PORT, a_val);
      i_rom_page1_en = 1'($urandom);
      i_ram_data = 8'($urandom);
      i_rom_data = ~i_ram_data;
      addr = 16'($urandom);
      mem_read(addr, expected_mem_data(addr, a_val, i_rom_page1_en, i_ram_data, i_rom_data));
      addr = 16'($urandom);
      slot = a_val[2*addr[15:14] +: 2];
      mem_write(addr, 8'($urandom), addr[15] && slot == 2'd0);
    end

    idle_cycles(8);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/msx_io_pkg.sv
verilog/cpu_clock_enable.sv
verilog/io_port_decoder.sv
verilog/vdp_port.sv
verilog/vdp_status.sv
verilog/ppi_ports.sv
verilog/slot_read_select.sv
verilog/msx_io_glue.sv
testbench/tb_msx_io_glue.sv
